// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing -j 0
TOP     = tb_mem_subsystem
FILES   = vlog.f
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILES)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/bank_arbiter.sv ====
// Routes word requests to one of two banks by the top word address bit
// Only one bank is open at a time and bank 0 is open after reset
// Opening the other bank holds ready low for OPEN_CYCLES cycles first
// OPEN_CYCLES must be at least 1
// BANK_WORDS should be a power of two no larger than half the word space
`timescale 1ns/1ns

module bank_arbiter import mem_pkg::*; #(
	parameter int BANK_WORDS  = 256,
	parameter int OPEN_CYCLES = 2
) (
	input  logic CLK,
	input  logic RSTb,
	bank_bus_if.responder cpu,
	bank_bus_if.requester bank0,
	bank_bus_if.requester bank1
);

	localparam int IDX_BITS = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;
	localparam int CNT_BITS = (OPEN_CYCLES > 1) ? $clog2(OPEN_CYCLES) : 1;
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(OPEN_CYCLES - 1);
	localparam int BANK_BIT = ADDR_BITS - 2; // Top byte address bit, seen in the word address

	logic                open_bank_r;
	logic                served_bank_r; // Bank whose read data is due this cycle
	logic [CNT_BITS-1:0] open_cnt_r;
	logic                req_bank;
	logic                bank_hit;
	addr_t               local_addr;

	assign req_bank   = cpu.addr[BANK_BIT];
	assign bank_hit   = (req_bank == open_bank_r);
	assign local_addr = addr_t'(cpu.addr[IDX_BITS-1:0]);

	// Both banks see the request fields and only valid is steered
	assign bank0.valid = cpu.valid && bank_hit && !open_bank_r;
	assign bank0.wr    = cpu.wr;
	assign bank0.addr  = local_addr;
	assign bank0.wdata = cpu.wdata;
	assign bank0.mask  = cpu.mask;

	assign bank1.valid = cpu.valid && bank_hit && open_bank_r;
	assign bank1.wr    = cpu.wr;
	assign bank1.addr  = local_addr;
	assign bank1.wdata = cpu.wdata;
	assign bank1.mask  = cpu.mask;

	// Ready does not look at valid, so there is no loop through the requester
	assign cpu.ready = bank_hit && (open_bank_r ? bank1.ready : bank0.ready);
	assign cpu.rdata = served_bank_r ? bank1.rdata : bank0.rdata;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			open_bank_r <= 1'b0;
			served_bank_r <= 1'b0;
			open_cnt_r <= '0;
		end else begin
			if (cpu.valid && !bank_hit) begin
				if (open_cnt_r == CNT_LAST) begin
					open_bank_r <= req_bank; // Served from the next cycle on
					open_cnt_r <= '0;
				end else begin
					open_cnt_r <= open_cnt_r + 1'b1;
				end
			end else begin
				open_cnt_r <= '0;
			end
			if (cpu.valid && cpu.ready)
				served_bank_r <= open_bank_r;
		end
	end

endmodule

// ==== design/bank_bus_if.sv ====
// Valid/ready request channel between a requester and a memory bank
// A transfer happens on a rising clock edge with valid and ready both high
// The address is a word address and read data follows one cycle after the transfer
`timescale 1ns/1ns

interface bank_bus_if import mem_pkg::*; ();

	logic     valid;
	logic     ready;
	logic     wr;    // High for a store
	addr_t    addr;  // Word address
	word_t    wdata;
	wr_mask_t mask;
	word_t    rdata;

	modport requester (
		output valid, wr, addr, wdata, mask,
		input  ready, rdata
	);

	modport responder (
		input  valid, wr, addr, wdata, mask,
		output ready, rdata
	);

endinterface

// ==== design/bank_ram.sv ====
// One memory bank of BANK_WORDS 16-bit words, indexed by the low word address bits
// Always ready. Writes land on the transfer edge under the byte mask
// Read data is registered and valid one cycle after a read transfer
// BANK_WORDS should be a power of two
`timescale 1ns/1ns

module bank_ram import mem_pkg::*; #(
	parameter int BANK_WORDS = 256
) (
	input  logic CLK,
	bank_bus_if.responder bus
);

	localparam int IDX_BITS = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

	word_t               mem [BANK_WORDS];
	word_t               rdata_r;
	logic [IDX_BITS-1:0] idx;
	logic                xfer;

	assign idx       = bus.addr[IDX_BITS-1:0];
	assign xfer      = bus.valid && bus.ready;
	assign bus.ready = 1'b1;
	assign bus.rdata = rdata_r;

	always_ff @(posedge CLK) begin
		if (xfer && bus.wr) begin
			if (bus.mask[0])
				mem[idx][7:0] <= bus.wdata[7:0];
			if (bus.mask[1])
				mem[idx][15:8] <= bus.wdata[15:8];
		end
		if (xfer && !bus.wr)
			rdata_r <= mem[idx]; // Holds until the next read
	end

endmodule

// ==== design/cpu_memory_interface.sv ====
// Memory request FSM on the CPU side of the bank arbiter
// The bus carries word addresses, the byte address shifted right by one
// A change of the top address bit between accesses inserts two wait states
// The next request is sampled on the edge where the current access transfers,
// so the CPU holds its request inputs until then
// The first fetch after reset is from address 0 and wake restarts at pc
// Halt is taken only in the execute state, once the pending fetch transfers
`timescale 1ns/1ns

module cpu_memory_interface import mem_pkg::*; (
	input  logic     CLK,
	input  logic     RSTb,
	input  logic     load_memory,
	input  logic     store_memory,
	input  logic     halt,
	input  logic     wake,
	input  addr_t    pc,
	input  addr_t    load_store_address,
	input  word_t    store_memory_data,
	input  wr_mask_t store_memory_wr_mask,
	bank_bus_if.requester bus,
	output logic     is_executing,
	output logic     is_fetching,
	output logic     memory_is_instruction,
	output wr_mask_t memory_wr_mask_delayed,
	output addr_t    memory_address_prev_plus_two
);

	mem_state_e state_r;
	mem_state_e state_next;
	mem_state_e req_state;

	addr_t    addr_r;          // Byte address of the access on the bus
	addr_t    req_addr;        // Address of the next request
	addr_t    prev_plus_two_r;
	word_t    wdata_r;
	wr_mask_t mask_r;
	wr_mask_t mask_del_r;
	logic     is_instr_r;
	logic     req_cross;
	logic     take_req;
	logic     xfer;

	function automatic logic has_bank_switch(addr_t a, addr_t b);
		return a[ADDR_BITS-1] ^ b[ADDR_BITS-1];
	endfunction

	assign xfer = bus.valid && bus.ready;

	// Loads win over stores when both are asked, as in the CPU decoder
	assign req_addr  = (load_memory || store_memory) ? load_store_address : pc;
	assign req_cross = has_bank_switch(req_addr, addr_r);

	always_comb begin
		if (load_memory)
			req_state = req_cross ? st_wait_load1 : st_execute_load;
		else if (store_memory)
			req_state = req_cross ? st_wait_store1 : st_execute_store;
		else
			req_state = req_cross ? st_wait_ready1 : st_execute;
	end

	always_comb begin
		state_next = state_r;
		take_req = 1'b0;
		case (state_r)
			st_halt:
				if (wake)
					state_next = st_wait_ready1;
			st_wait_ready1:
				state_next = st_wait_ready2;
			st_wait_load1:
				state_next = st_wait_load2;
			st_wait_store1:
				state_next = st_wait_store2;
			st_execute: begin
				if (xfer && halt) begin
					state_next = st_halt; // The next fetch is dropped until wake
				end else if (xfer) begin
					take_req = 1'b1;
					state_next = req_state;
				end
			end
			st_wait_ready2,
			st_execute_load,
			st_wait_load2,
			st_execute_store,
			st_wait_store2: begin
				if (xfer) begin
					take_req = 1'b1;
					state_next = req_state;
				end
			end
			default:
				state_next = st_halt;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= st_wait_ready1;
			addr_r <= '0;
			mask_r <= MASK_ALL;
			mask_del_r <= MASK_ALL;
			is_instr_r <= 1'b0;
		end else begin
			state_r <= state_next;
			if (state_r == st_halt && wake) begin
				addr_r <= pc;
				mask_r <= MASK_ALL;
			end else if (take_req) begin
				addr_r <= req_addr;
				// Loads keep their byte mask so writeback can pick the byte
				mask_r <= (load_memory || store_memory) ? store_memory_wr_mask : MASK_ALL;
			end
			if (xfer) begin
				mask_del_r <= mask_r;
				is_instr_r <= is_fetching;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (take_req)
			wdata_r <= store_memory_data;
		if (xfer)
			prev_plus_two_r <= addr_r + addr_t'(2); // Return address after a fetch
	end

	always_comb begin
		bus.valid = 1'b0;
		bus.wr = 1'b0;
		case (state_r)
			st_execute,
			st_wait_ready2,
			st_execute_load,
			st_wait_load2:
				bus.valid = 1'b1;
			st_execute_store,
			st_wait_store2: begin
				bus.valid = 1'b1;
				bus.wr = 1'b1;
			end
			default: ;
		endcase
	end

	assign bus.addr  = {1'b0, addr_r[ADDR_BITS-1:1]};
	assign bus.wdata = wdata_r;
	assign bus.mask  = mask_r;

	assign is_executing = (state_r == st_execute) || (state_r == st_execute_load) ||
		(state_r == st_execute_store);
	assign is_fetching  = (state_r == st_execute) || (state_r == st_wait_ready2);

	assign memory_is_instruction        = is_instr_r;
	assign memory_wr_mask_delayed       = mask_del_r;
	assign memory_address_prev_plus_two = prev_plus_two_r;

endmodule

// ==== design/mem_pkg.sv ====
// Shared types for the CPU memory side
// Words and byte addresses are both 16 bits wide
// The top byte address bit selects one of two banks
// Write mask bit 0 enables the low byte and bit 1 the high byte
package mem_pkg;

	localparam int WORD_BITS = 16;
	localparam int ADDR_BITS = 16;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [1:0] wr_mask_t;

	localparam wr_mask_t MASK_ALL = 2'b11; // Both byte lanes

	// States of the CPU memory interface FSM
	typedef enum logic [3:0] {
		st_halt          = 4'd0, // Sleeping, no requests issued
		st_execute       = 4'd1, // Fetching in the open bank
		st_wait_ready1   = 4'd2, // Bank change dead cycle before a fetch
		st_wait_ready2   = 4'd3, // Fetch in a newly opened bank
		st_execute_load  = 4'd4,
		st_wait_load1    = 4'd5,
		st_wait_load2    = 4'd6,
		st_execute_store = 4'd7,
		st_wait_store1   = 4'd8,
		st_wait_store2   = 4'd9
	} mem_state_e;

endpackage

// ==== design/mem_subsystem_top.sv ====
// Memory side of the 16-bit CPU with two banks behind one arbiter
// memory_address is the word address of the CPU side request
// memory_in is valid one cycle after a read transfer
`timescale 1ns/1ns

module mem_subsystem_top import mem_pkg::*; #(
	parameter int BANK_WORDS  = 256,
	parameter int OPEN_CYCLES = 2
) (
	input  logic     CLK,
	input  logic     RSTb,
	input  logic     load_memory,
	input  logic     store_memory,
	input  logic     halt,
	input  logic     wake,
	input  addr_t    pc,
	input  addr_t    load_store_address,
	input  word_t    store_memory_data,
	input  wr_mask_t store_memory_wr_mask,
	output addr_t    memory_address,
	output word_t    memory_in,
	output logic     memory_valid,
	output logic     memory_ready,
	output logic     memory_wr,
	output wr_mask_t memory_wr_mask,
	output wr_mask_t memory_wr_mask_delayed,
	output logic     is_executing,
	output logic     is_fetching,
	output logic     memory_is_instruction,
	output addr_t    memory_address_prev_plus_two
);

	bank_bus_if cpu_bus ();
	bank_bus_if bank0_bus ();
	bank_bus_if bank1_bus ();

	cpu_memory_interface mem_if_i (
		.CLK, .RSTb,
		.load_memory, .store_memory, .halt, .wake,
		.pc, .load_store_address, .store_memory_data, .store_memory_wr_mask,
		.bus(cpu_bus),
		.is_executing, .is_fetching, .memory_is_instruction,
		.memory_wr_mask_delayed, .memory_address_prev_plus_two
	);

	bank_arbiter #(
		.BANK_WORDS(BANK_WORDS),
		.OPEN_CYCLES(OPEN_CYCLES)
	) arbiter_i (
		.CLK, .RSTb,
		.cpu(cpu_bus),
		.bank0(bank0_bus),
		.bank1(bank1_bus)
	);

	bank_ram #(.BANK_WORDS(BANK_WORDS)) bank0_i (.CLK, .bus(bank0_bus));
	bank_ram #(.BANK_WORDS(BANK_WORDS)) bank1_i (.CLK, .bus(bank1_bus));

	// The CPU side handshake is visible outside
	assign memory_address = cpu_bus.addr;
	assign memory_in      = cpu_bus.rdata;
	assign memory_valid   = cpu_bus.valid;
	assign memory_ready   = cpu_bus.ready;
	assign memory_wr      = cpu_bus.wr;
	assign memory_wr_mask = cpu_bus.mask;

endmodule

// ==== testbench/tb_model.svh ====
// Reference model and checks for the memory subsystem testbench
// The model memory spans the whole word space and starts at zero
// Only the bank bit and the low bank index bits of an address are used,
// so words never alias inside a bank
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int ERR_DATA   = 0; // Read data
localparam int ERR_ACCESS = 1; // Address, kind and mask on the bus
localparam int ERR_STATUS = 2; // Delayed mask, return address, instruction flag
localparam int ERR_HALT   = 3;
localparam int ERR_BANK   = 4; // Open penalty and ready in the open bank

localparam logic [1:0] KIND_FETCH = 2'd0;
localparam logic [1:0] KIND_LOAD  = 2'd1;
localparam logic [1:0] KIND_STORE = 2'd2;

word_t model_mem [1 << (ADDR_BITS - 1)];
int    err_cnt [5];

// The access the DUT should present next
logic [1:0] pend_kind;
addr_t      pend_addr;
wr_mask_t   pend_mask;
word_t      pend_data;
logic       pend_exec;   // Plain fetch in the open bank, the only place halt is taken
int         wait_cycles; // Cycles it has waited with valid high and ready low

// The access transferred on the last edge
logic       last_xfer;
logic [1:0] last_kind;
addr_t      last_addr;
wr_mask_t   last_mask;
logic       open_bank;

function automatic logic bank_of(addr_t a);
	return a[ADDR_BITS-1];
endfunction

function automatic word_t model_read(addr_t byte_addr);
	return model_mem[int'(byte_addr >> 1)];
endfunction

function automatic void apply_write(addr_t byte_addr, word_t data, wr_mask_t mask);
	int w;
	w = int'(byte_addr >> 1);
	if (mask[0])
		model_mem[w][7:0] = data[7:0];
	if (mask[1])
		model_mem[w][15:8] = data[15:8];
endfunction

task automatic check_word(string name, word_t got, word_t exp, int kind);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		err_cnt[kind]++;
	end
endtask

task automatic check_addr(string name, addr_t got, addr_t exp, int kind);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		err_cnt[kind]++;
	end
endtask

task automatic check_mask(string name, wr_mask_t got, wr_mask_t exp, int kind);
	if (got !== exp) begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		err_cnt[kind]++;
	end
endtask

task automatic check_flag(string name, logic got, logic exp, int kind);
	if (got !== exp) begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		err_cnt[kind]++;
	end
endtask

task automatic expect_fetch(addr_t a);
	pend_kind = KIND_FETCH;
	pend_addr = a;
	pend_mask = MASK_ALL;
	pend_data = '0;
	pend_exec = 1'b0; // Reset and wake both pass through a wait state
	wait_cycles = 0;
endtask

task automatic init_model();
	foreach (model_mem[i])
		model_mem[i] = '0;
	foreach (err_cnt[i])
		err_cnt[i] = 0;
	open_bank = 1'b0;
	last_xfer = 1'b0;
	last_kind = KIND_FETCH;
	last_addr = '0;
	last_mask = MASK_ALL;
	expect_fetch('0); // First fetch after reset
endtask

// The request on the inputs is taken on the edge where the pending access transfers
task automatic take_driven_request();
	addr_t next_addr;
	next_addr = (load_memory || store_memory) ? load_store_address : pc;
	pend_exec = !load_memory && !store_memory && (bank_of(next_addr) == bank_of(pend_addr));
	pend_kind = load_memory ? KIND_LOAD : (store_memory ? KIND_STORE : KIND_FETCH);
	pend_addr = next_addr;
	pend_mask = (load_memory || store_memory) ? store_memory_wr_mask : MASK_ALL;
	pend_data = store_memory_data;
endtask

task automatic check_request();
	check_addr("memory_address", memory_address, pend_addr >> 1, ERR_ACCESS);
	check_flag("memory_wr", memory_wr, pend_kind == KIND_STORE, ERR_ACCESS);
	check_mask("memory_wr_mask", memory_wr_mask, pend_mask, ERR_ACCESS);
	check_flag("is_fetching", is_fetching, pend_kind == KIND_FETCH, ERR_ACCESS);
endtask

task automatic note_stall();
	wait_cycles++;
	if (bank_of(pend_addr) == open_bank) begin
		$display("Ready low at %0t although bank %0d is already open", $time, open_bank);
		err_cnt[ERR_BANK]++;
	end
endtask

task automatic record_transfer();
	if (bank_of(pend_addr) != open_bank && wait_cycles < OPEN_CYCLES) begin
		$display("Bank %0d served at %0t after only %0d wait cycles, the open penalty is %0d",
			bank_of(pend_addr), $time, wait_cycles, OPEN_CYCLES);
		err_cnt[ERR_BANK]++;
	end
	open_bank = bank_of(pend_addr);
	wait_cycles = 0;
	if (pend_kind == KIND_STORE)
		apply_write(pend_addr, pend_data, pend_mask);
	last_xfer = 1'b1;
	last_kind = pend_kind;
	last_addr = pend_addr;
	last_mask = pend_mask;
endtask

task automatic check_after_transfer(logic check_data);
	if (check_data && last_kind != KIND_STORE)
		check_word("memory_in", memory_in, model_read(last_addr), ERR_DATA);
	check_mask("memory_wr_mask_delayed", memory_wr_mask_delayed, last_mask, ERR_STATUS);
	check_addr("memory_address_prev_plus_two", memory_address_prev_plus_two,
		last_addr + addr_t'(2), ERR_STATUS);
	check_flag("memory_is_instruction", memory_is_instruction, last_kind == KIND_FETCH,
		ERR_STATUS);
endtask

function automatic int error_total();
	int sum;
	sum = 0;
	foreach (err_cnt[i])
		sum += err_cnt[i];
	return sum;
endfunction

task automatic print_counts();
	$display("Errors: data %0d, access %0d, status %0d, halt %0d, bank %0d",
		err_cnt[ERR_DATA], err_cnt[ERR_ACCESS], err_cnt[ERR_STATUS],
		err_cnt[ERR_HALT], err_cnt[ERR_BANK]);
endtask

`endif

// ==== testbench/tb_mem_subsystem.sv ====
// Testbench for the two-bank memory subsystem, playing the CPU
// Every bank word is first written with zero, then random fetches, loads
// and stores run with occasional halt and wake
// Outputs are sampled and inputs driven on the falling clock edge
`timescale 1ns/1ns

module tb_mem_subsystem import mem_pkg::*; ();

	localparam int BANK_WORDS  = 256;
	localparam int OPEN_CYCLES = 2;
	localparam int RAND_CYCLES = 4000;
	localparam int MAX_CYCLES  = (RAND_CYCLES + 2 * BANK_WORDS) * 4;

	logic     CLK;
	logic     RSTb;
	logic     load_memory;
	logic     store_memory;
	logic     halt;
	logic     wake;
	addr_t    pc;
	addr_t    load_store_address;
	word_t    store_memory_data;
	wr_mask_t store_memory_wr_mask;
	addr_t    memory_address;
	word_t    memory_in;
	logic     memory_valid;
	logic     memory_ready;
	logic     memory_wr;
	wr_mask_t memory_wr_mask;
	wr_mask_t memory_wr_mask_delayed;
	logic     is_executing;
	logic     is_fetching;
	logic     memory_is_instruction;
	addr_t    memory_address_prev_plus_two;

	logic [31:0] rng_state;
	int          cycles_run;
	int          rand_cycles;
	int          pre_idx;     // Next bank word to clear
	int          pre_stored;  // Clearing stores already transferred
	logic        reads_valid; // Banks hold known data from here on
	logic        need_new;
	logic        halted;
	int          halt_wait;

	`include "tb_model.svh"

	mem_subsystem_top #(
		.BANK_WORDS(BANK_WORDS),
		.OPEN_CYCLES(OPEN_CYCLES)
	) dut_i (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_random(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	function automatic addr_t make_addr(logic bank, int idx);
		addr_t a;
		a = addr_t'(idx % BANK_WORDS) << 1;
		a[ADDR_BITS-1] = bank;
		return a;
	endfunction

	task automatic pick_request();
		logic [31:0] r;
		logic        bank;
		addr_t       target;
		if (pre_idx < 2 * BANK_WORDS) begin
			load_memory = 1'b0;
			store_memory = 1'b1;
			load_store_address = make_addr(pre_idx >= BANK_WORDS, pre_idx);
			store_memory_data = '0;
			store_memory_wr_mask = MASK_ALL;
			pre_idx++;
		end else begin
			next_random(r);
			bank = bank_of(pend_addr) ^ ((r[31:16] % 16'd3) == 16'd0); // About a third cross
			target = make_addr(bank, int'(r[15:8]));
			load_memory = (r[1:0] == 2'd2);
			store_memory = (r[1:0] == 2'd3);
			next_random(r);
			store_memory_data = r[15:0];
			store_memory_wr_mask = r[17:16];
			if (load_memory || store_memory) begin
				load_store_address = target;
				pc = make_addr(r[18], int'(r[27:20]));
			end else begin
				pc = target;
				load_store_address = make_addr(r[18], int'(r[27:20]));
			end
		end
	endtask

	initial begin
		cycles_run = 0;
		while (cycles_run < MAX_CYCLES) begin
			@(posedge CLK);
			cycles_run++;
		end
		$display("Timeout, the test did not finish within %0d cycles", MAX_CYCLES);
		print_counts();
		$display("** FAIL **");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic        s_valid;
		logic        s_ready;
		RSTb = 1'b0;
		load_memory = 1'b0;
		store_memory = 1'b0;
		halt = 1'b0;
		wake = 1'b0;
		pc = '0;
		load_store_address = '0;
		store_memory_data = '0;
		store_memory_wr_mask = MASK_ALL;
		rng_state = 32'd5746;
		rand_cycles = 0;
		pre_idx = 0;
		pre_stored = 0;
		reads_valid = 1'b0;
		need_new = 1'b0;
		halted = 1'b0;
		halt_wait = 0;
		init_model();
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
		pick_request();
		while (rand_cycles < RAND_CYCLES) begin
			@(negedge CLK);
			if (reads_valid)
				rand_cycles++;
			s_valid = memory_valid;
			s_ready = memory_ready;
			if (last_xfer)
				check_after_transfer(reads_valid);
			last_xfer = 1'b0;
			halt = 1'b0;
			wake = 1'b0;
			if (need_new) begin
				pick_request();
				need_new = 1'b0;
			end
			if (reads_valid && !halted) begin
				next_random(r);
				halt = (r[3:0] == 4'd0); // Ignored unless a fetch in the open bank transfers
			end
			if (halted) begin
				if (s_valid || is_executing) begin
					$display("Memory request or execution seen at %0t while halted", $time);
					err_cnt[ERR_HALT]++;
				end
				if (halt_wait == 0) begin
					wake = 1'b1;
					halted = 1'b0;
					expect_fetch(pc);
				end else begin
					halt_wait--;
				end
			end else if (s_valid) begin
				check_request();
				if (s_ready) begin
					if (!reads_valid && pend_kind == KIND_STORE) begin
						pre_stored++;
						reads_valid = (pre_stored == 2 * BANK_WORDS);
					end
					record_transfer();
					if (halt && pend_exec) begin
						halted = 1'b1;
						halt_wait = int'(r[6:4]);
					end else begin
						take_driven_request();
					end
					need_new = 1'b1;
				end else begin
					note_stall();
				end
			end
		end
		print_counts();
		if (error_total() == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
design/mem_pkg.sv
design/bank_bus_if.sv
design/bank_ram.sv
design/bank_arbiter.sv
design/cpu_memory_interface.sv
design/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv
